/* common/adpcm_pkg.sv */
`default_nettype none

package adpcm_pkg;

    // voice count equals the decoder pipeline depth
    localparam int num_voices = 6;

    typedef logic [2:0] voice_t;
    // bit 3 sign, bits 2..0 magnitude
    typedef logic [3:0] code_t;

    // fifo payload, voice in the upper bits
    typedef struct packed {
        voice_t voice;
        code_t  code;
    } nibble_entry_t;

    typedef logic [5:0] step_t;
    localparam step_t step_max = 6'd48;

    // one bit over the 12-bit signal for overflow headroom
    localparam int acc_w = 13;
    typedef logic signed [acc_w-1:0] acc_t;
    localparam acc_t acc_max = 13'sd2047;
    localparam acc_t acc_min = -13'sd2048;

    typedef logic signed [15:0] pcm_t;

    // standard ADPCM-A step sizes
    localparam logic [11:0] step_size_table [0:48] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,
        12'd31,   12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,
        12'd60,   12'd66,   12'd73,   12'd80,   12'd88,   12'd97,   12'd107,
        12'd118,  12'd130,  12'd143,  12'd157,  12'd173,  12'd190,  12'd209,
        12'd230,  12'd253,  12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,  12'd724,  12'd796,
        12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // apb bus widths and register map
    localparam int apb_addr_w = 4;
    localparam int apb_data_w = 32;
    localparam logic [apb_addr_w-1:0] reg_ctrl   = 4'h0;
    localparam logic [apb_addr_w-1:0] reg_clear  = 4'h4;
    localparam logic [apb_addr_w-1:0] reg_data   = 4'h8;
    localparam logic [apb_addr_w-1:0] reg_status = 4'hC;

endpackage

`default_nettype wire

/* common/nibble_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface nibble_fifo_if #(
    parameter int FIFO_DEPTH = 16
) ();
    import adpcm_pkg::*;

    // level counts 0..FIFO_DEPTH inclusive
    localparam int lvl_w = $clog2(FIFO_DEPTH + 1);

    logic                push;
    nibble_entry_t       push_data;
    logic                full;
    logic                pop;
    nibble_entry_t       pop_data;
    logic                empty;
    logic [lvl_w-1:0]    level;

    // apb side writes codes
    modport producer (output push, output push_data, input full, input level);
    // storage side
    modport buffer (input push, input push_data, input pop,
                    output full, output empty, output pop_data, output level);
    // slot sequencer side
    modport consumer (output pop, input pop_data, input empty);

endinterface

`default_nettype wire

/* design/adpcm_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module adpcm_apb_regs #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 psel,
    input  wire logic                                 penable,
    input  wire logic                                 pwrite,
    input  wire logic [adpcm_pkg::apb_addr_w-1:0]     paddr,
    input  wire logic [adpcm_pkg::apb_data_w-1:0]     pwdata,
    output logic      [adpcm_pkg::apb_data_w-1:0]     prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output logic      [adpcm_pkg::num_voices-1:0]     voice_on,
    output logic      [adpcm_pkg::num_voices-1:0]     clear_req,
    nibble_fifo_if.producer                           fifo
);
    import adpcm_pkg::*;

    localparam int lvl_w = $clog2(FIFO_DEPTH + 1);

    logic wr_acc;
    logic data_wr;
    logic [apb_data_w-1:0] status_word;

    // write completes in the access phase, no wait states
    assign wr_acc  = psel & penable & pwrite;
    assign data_wr = wr_acc & (paddr == reg_data);
    assign pready  = 1'b1;

    // code write into a full fifo is refused
    assign pslverr = data_wr & fifo.full;

    // push only when there is room
    assign fifo.push      = data_wr & ~fifo.full;
    assign fifo.push_data = '{voice: voice_t'(pwdata[6:4]), code: code_t'(pwdata[3:0])};

    // level in the low bits, full flag at bit 8
    always_comb begin
        status_word              = '0;
        status_word[lvl_w-1:0]   = fifo.level;
        status_word[8]           = fifo.full;
    end

    // read mux, unmapped offsets read zero
    always_comb begin
        prdata = '0;
        case (paddr)
            reg_ctrl:   prdata[num_voices-1:0] = voice_on;
            reg_status: prdata = status_word;
            default:    prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            voice_on  <= '0;
            clear_req <= '0;
        end else begin
            // clear request is a single-cycle pulse
            clear_req <= '0;
            if (wr_acc && paddr == reg_ctrl) begin
                voice_on <= pwdata[num_voices-1:0];
            end
            if (wr_acc && paddr == reg_clear) begin
                clear_req <= pwdata[num_voices-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* design/nibble_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module nibble_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    nibble_fifo_if.buffer  fifo
);
    import adpcm_pkg::*;

    localparam int ptr_w = $clog2(FIFO_DEPTH);
    localparam int lvl_w = $clog2(FIFO_DEPTH + 1);

    nibble_entry_t    mem [FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [lvl_w-1:0] level;
    logic             do_push;
    logic             do_pop;

    // guard against protocol misuse on either side
    assign do_push = fifo.push & ~fifo.full;
    assign do_pop  = fifo.pop & ~fifo.empty;

    assign fifo.full     = (level == lvl_w'(FIFO_DEPTH));
    assign fifo.empty    = (level == '0);
    assign fifo.level    = level;
    // head entry, valid while not empty
    assign fifo.pop_data = mem[rd_ptr];

    // storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= fifo.push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            // pointers wrap at depth, not only at powers of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the level
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* adpcm_decoder/adpcm_step_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module adpcm_step_lut (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [8:0]  addr,
    output logic      [11:0] inc
);
    import adpcm_pkg::*;

    step_t       idx;
    step_t       idx_safe;
    logic [2:0]  mag;
    logic [11:0] size;
    // 1552 * 15 fits in 15 bits
    logic [14:0] prod;

    // step index upper, magnitude lower
    assign idx = addr[8:3];
    assign mag = addr[2:0];

    // out-of-range index reads the top entry
    assign idx_safe = (idx > step_max) ? step_max : idx;
    assign size     = step_size_table[idx_safe];

    // size * (2m+1)
    assign prod = size * {mag, 1'b1};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inc <= '0;
        end else begin
            // divide by 8, truncated
            inc <= prod[14:3];
        end
    end

endmodule

`default_nettype wire

/* adpcm_decoder/adpcm_decode_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module adpcm_decode_pipe (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire adpcm_pkg::code_t     code,
    input  wire logic                 code_valid,
    input  wire logic                 voice_clr,
    input  wire adpcm_pkg::voice_t    slot,
    output adpcm_pkg::pcm_t           pcm,
    output adpcm_pkg::voice_t         pcm_voice,
    output logic                      pcm_valid
);
    import adpcm_pkg::*;

    // accumulator and step ring, one voice per stage
    acc_t   acc1, acc2, acc3, acc4, acc6;
    step_t  step1, step2, step3, step4, step5, step6;
    logic   valid1, valid2, valid3, valid4, valid5, valid6;
    voice_t tag1, tag2, tag3, tag4, tag5, tag6;
    logic   sign2, sign3;
    // extra bit so the clamp sees the true sum
    logic signed [acc_w:0] sum5;
    acc_t   inc4;
    acc_t   inc_ext;
    logic [8:0]  lut_addr2;
    logic [11:0] inc3;
    // stage I working values
    acc_t   acc_in;
    step_t  step_in;
    step_t  step_next;
    step_t  step_new;
    pcm_t   acc_wide;

    // clear takes effect before this slot's code
    assign acc_in  = voice_clr ? '0 : acc1;
    assign step_in = voice_clr ? '0 : step1;

    // step adaptation
    always_comb begin
        casez (code[2:0])
            3'b0??:  step_next = (step_in == '0) ? '0 : step_in - 1'b1;
            3'b100:  step_next = step_in + 6'd2;
            3'b101:  step_next = step_in + 6'd5;
            3'b110:  step_next = step_in + 6'd7;
            default: step_next = step_in + 6'd9;
        endcase
        step_new = (step_next > step_max) ? step_max : step_next;
    end

    adpcm_step_lut adpcm_step_lut_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (lut_addr2),
        .inc   (inc3)
    );

    assign inc_ext = {{(acc_w - 12){1'b0}}, inc3};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc1 <= '0; acc2 <= '0;
            acc3 <= '0; acc4 <= '0;
            acc6 <= '0; sum5 <= '0;
            step1 <= '0; step2 <= '0; step3 <= '0;
            step4 <= '0; step5 <= '0; step6 <= '0;
            valid1 <= 1'b0; valid2 <= 1'b0; valid3 <= 1'b0;
            valid4 <= 1'b0; valid5 <= 1'b0; valid6 <= 1'b0;
            tag1 <= '0; tag2 <= '0; tag3 <= '0;
            tag4 <= '0; tag5 <= '0; tag6 <= '0;
            sign2 <= 1'b0;
            sign3 <= 1'b0;
            inc4 <= '0;
            lut_addr2 <= '0;
        end else begin
            // I: next step, table address
            acc2      <= acc_in;
            step2     <= code_valid ? step_new : step_in;
            sign2     <= code[3];
            valid2    <= code_valid;
            tag2      <= slot;
            lut_addr2 <= {step_in, code[2:0]};
            // II: table lookup in flight
            acc3   <= acc2;
            step3  <= step2;
            sign3  <= sign2;
            valid3 <= valid2;
            tag3   <= tag2;
            // III: apply the sign
            inc4   <= sign3 ? -inc_ext : inc_ext;
            acc4   <= acc3;
            step4  <= step3;
            valid4 <= valid3;
            tag4   <= tag3;
            // IV: accumulate, only when a code was decoded
            sum5   <= valid4 ? ({acc4[acc_w-1], acc4} + {inc4[acc_w-1], inc4})
                             : {acc4[acc_w-1], acc4};
            step5  <= step4;
            valid5 <= valid4;
            tag5   <= tag4;
            // V: saturate to 12 bits
            if (sum5 > acc_max) begin
                acc6 <= acc_max;
            end else if (sum5 < acc_min) begin
                acc6 <= acc_min;
            end else begin
                acc6 <= acc_t'(sum5);
            end
            step6  <= step5;
            valid6 <= valid5;
            tag6   <= tag5;
            // VI: back to stage I
            acc1   <= acc6;
            step1  <= step6;
            valid1 <= valid6;
            tag1   <= tag6;
        end
    end

    // output taken at stage I, sign extended then scaled by 8
    assign acc_wide  = pcm_t'(acc1);
    assign pcm       = acc_wide <<< 3;
    assign pcm_voice = tag1;
    assign pcm_valid = valid1;

endmodule

`default_nettype wire

/* adpcm_decoder/adpcm_slot_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module adpcm_slot_sequencer (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic [adpcm_pkg::num_voices-1:0] voice_on,
    input  wire logic [adpcm_pkg::num_voices-1:0] clear_req,
    nibble_fifo_if.consumer                       fifo,
    output adpcm_pkg::code_t                      code,
    output logic                                  code_valid,
    output logic                                  voice_clr,
    output adpcm_pkg::voice_t                     slot
);
    import adpcm_pkg::*;

    logic [num_voices-1:0] pend_clr;
    logic [num_voices-1:0] slot_mask;
    logic                  head_hit;
    logic                  head_bad;

    assign slot_mask = {{(num_voices - 1){1'b0}}, 1'b1} << slot;

    // head entry belongs to the current slot
    assign head_hit = ~fifo.empty & (fifo.pop_data.voice == slot);
    // voice numbers with no slot would block the fifo forever, drop them
    assign head_bad = ~fifo.empty & (fifo.pop_data.voice > voice_t'(num_voices - 1));

    assign fifo.pop = head_hit | head_bad;

    // disabled voice, code is popped but not decoded
    assign code       = fifo.pop_data.code;
    assign code_valid = head_hit & voice_on[slot];

    // pending clear applies in its own slot
    assign voice_clr = pend_clr[slot];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot     <= '0;
            pend_clr <= '0;
        end else begin
            // one slot per clock, 0..5
            if (slot == voice_t'(num_voices - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
            // release the served clear, latch new requests
            pend_clr <= (pend_clr & ~slot_mask) | clear_req;
        end
    end

endmodule

`default_nettype wire

/* design/adpcm_playback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module adpcm_playback_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             psel,
    input  wire logic                             penable,
    input  wire logic                             pwrite,
    input  wire logic [adpcm_pkg::apb_addr_w-1:0] paddr,
    input  wire logic [adpcm_pkg::apb_data_w-1:0] pwdata,
    output logic      [adpcm_pkg::apb_data_w-1:0] prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output adpcm_pkg::pcm_t                       pcm,
    output adpcm_pkg::voice_t                     pcm_voice,
    output logic                                  pcm_valid
);
    import adpcm_pkg::*;

    logic [num_voices-1:0] voice_on;
    logic [num_voices-1:0] clear_req;
    code_t                 code;
    logic                  code_valid;
    logic                  voice_clr;
    voice_t                slot;

    nibble_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_bus ();

    // cpu side, pushes codes
    adpcm_apb_regs #(.FIFO_DEPTH(FIFO_DEPTH)) adpcm_apb_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .voice_on  (voice_on),
        .clear_req (clear_req),
        .fifo      (fifo_bus.producer)
    );

    nibble_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) nibble_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .fifo  (fifo_bus.buffer)
    );

    // slot rotation feeding the decoder
    adpcm_slot_sequencer adpcm_slot_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .voice_on   (voice_on),
        .clear_req  (clear_req),
        .fifo       (fifo_bus.consumer),
        .code       (code),
        .code_valid (code_valid),
        .voice_clr  (voice_clr),
        .slot       (slot)
    );

    adpcm_decode_pipe adpcm_decode_pipe_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .code       (code),
        .code_valid (code_valid),
        .voice_clr  (voice_clr),
        .slot       (slot),
        .pcm        (pcm),
        .pcm_voice  (pcm_voice),
        .pcm_valid  (pcm_valid)
    );

endmodule

`default_nettype wire

/* verif/adpcm_playback_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module adpcm_playback_tb;
    import adpcm_pkg::*;

    localparam int FIFO_DEPTH  = 16;
    localparam int drain_limit = 4000;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    pcm_t                  pcm;
    voice_t                pcm_voice;
    logic                  pcm_valid;

    // reference model state, one entry per voice
    int                    model_acc [num_voices];
    int                    model_step [num_voices];
    pcm_t                  exp_pcm [num_voices][$];
    voice_t                exp_order [$];
    pcm_t                  last_pcm [num_voices];
    logic [num_voices-1:0] voice_mask;
    logic [31:0]           lfsr_state;
    int                    err_count;
    int                    check_count;
    string                 test_name;

    adpcm_playback_top #(.FIFO_DEPTH(FIFO_DEPTH)) adpcm_playback_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pcm       (pcm),
        .pcm_voice (pcm_voice),
        .pcm_valid (pcm_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // overall limit on run time
    initial begin
        #1_000_000;
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    task automatic check_pcm(input string name, input pcm_t exp, input pcm_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: pcm expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_voice(input string name, input voice_t exp, input voice_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: voice expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input logic [apb_data_w-1:0] exp,
                                input logic [apb_data_w-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: register expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    // galois lfsr, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'hD0000001;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // adpcm-a rules: size*(2m+1)/8, clamp to 12 bits, adapt step
    function automatic pcm_t predict_pcm(input voice_t v, input code_t c);
        int mag;
        int inc;
        int acc;
        int step;
        mag  = int'(c[2:0]);
        step = model_step[v];
        inc  = (int'(step_size_table[step]) * (2 * mag + 1)) / 8;
        acc  = c[3] ? model_acc[v] - inc : model_acc[v] + inc;
        if (acc > int'(acc_max)) begin
            acc = int'(acc_max);
        end else if (acc < int'(acc_min)) begin
            acc = int'(acc_min);
        end
        case (mag)
            4:       step = step + 2;
            5:       step = step + 5;
            6:       step = step + 7;
            7:       step = step + 9;
            default: step = (step > 0) ? step - 1 : 0;
        endcase
        if (step > int'(step_max)) begin
            step = int'(step_max);
        end
        model_acc[v]  = acc;
        model_step[v] = step;
        return pcm_t'(acc * 8);
    endfunction

    // one apb transfer, entered and left just after a rising edge
    task automatic apb_xfer(input logic wr, input logic [apb_addr_w-1:0] addr,
                            input logic [apb_data_w-1:0] data,
                            output logic [apb_data_w-1:0] rdata, output logic err);
        int waits;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready && waits < 16) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            err_count++;
            $display("no pready on APB access to offset 0x%0h", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_status(output logic [apb_data_w-1:0] status);
        logic err;
        apb_xfer(1'b0, reg_status, '0, status, err);
    endtask

    task automatic set_voices(input logic [num_voices-1:0] mask);
        logic [apb_data_w-1:0] rd;
        logic                  err;
        apb_xfer(1'b1, reg_ctrl, apb_data_w'(mask), rd, err);
        voice_mask = mask;
        apb_xfer(1'b0, reg_ctrl, '0, rd, err);
        check_status(test_name, apb_data_w'(mask), rd);
    endtask

    // single write attempt, model follows only accepted codes of enabled voices
    task automatic push_code(input voice_t v, input code_t c, output logic err);
        logic [apb_data_w-1:0] rd;
        pcm_t                  exp_val;
        apb_xfer(1'b1, reg_data, {25'd0, v, c}, rd, err);
        if (!err && voice_mask[v]) begin
            exp_val = predict_pcm(v, c);
            exp_pcm[v].push_back(exp_val);
            exp_order.push_back(v);
        end
    endtask

    // retried while the fifo is full
    task automatic send_code(input voice_t v, input code_t c);
        logic err;
        int   tries;
        tries = 0;
        push_code(v, c, err);
        while (err && tries < 64) begin
            tries++;
            push_code(v, c, err);
        end
        if (err) begin
            err_count++;
            $display("code for voice %0d kept being refused in %s", v, test_name);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_order.size() != 0 && cycles < drain_limit) begin
            cycles++;
            @(negedge clk);
        end
        if (exp_order.size() != 0) begin
            err_count++;
            $display("%0d outputs never arrived in %s", exp_order.size(), test_name);
        end
        idle(12);
    endtask

    // returns just after the edge on which voice v's slot pops
    task automatic wait_voice_out(input voice_t v);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(pcm_valid && pcm_voice == v) && cycles < 200) begin
            cycles++;
            @(negedge clk);
        end
        if (!(pcm_valid && pcm_voice == v)) begin
            err_count++;
            $display("no output from voice %0d in %s", v, test_name);
        end
        @(posedge clk);
        #1;
    endtask

    // every output pulse against the model, in fifo order
    always @(negedge clk) begin : pcm_monitor
        voice_t v;
        if (rst_n && pcm_valid) begin
            if (exp_order.size() == 0) begin
                err_count++;
                $display("unexpected output for voice %0d in %s", pcm_voice, test_name);
            end else begin
                v = exp_order.pop_front();
                check_voice(test_name, v, pcm_voice);
                if (exp_pcm[v].size() != 0) begin
                    check_pcm(test_name, exp_pcm[v].pop_front(), pcm);
                end
                last_pcm[v] = pcm;
            end
        end
    end

    task automatic test_single_voice();
        int i;
        test_name = "single_voice";
        set_voices(6'b000001);
        // step up to 25
        send_code(3'd0, 4'h4);
        send_code(3'd0, 4'h5);
        send_code(3'd0, 4'h6);
        send_code(3'd0, 4'h7);
        send_code(3'd0, 4'hC);
        // long run of small magnitudes reaches the floor
        for (i = 0; i < 30; i++) begin
            send_code(3'd0, code_t'({i[2], 1'b0, i[1:0]}));
        end
        wait_drain();
    endtask

    task automatic test_all_voices();
        int     i;
        voice_t v;
        test_name = "all_voices";
        set_voices(6'h3F);
        for (i = 0; i < 72; i++) begin
            v = voice_t'(rand_bits(3) % num_voices);
            send_code(v, code_t'(rand_bits(4)));
        end
        wait_drain();
    endtask

    task automatic test_saturation();
        int i;
        test_name = "saturation";
        for (i = 0; i < 24; i++) begin
            send_code(3'd1, 4'h7);
        end
        wait_drain();
        check_pcm(test_name, pcm_t'(2047 * 8), last_pcm[1]);
        for (i = 0; i < 24; i++) begin
            send_code(3'd1, 4'hF);
        end
        wait_drain();
        check_pcm(test_name, pcm_t'(-2048 * 8), last_pcm[1]);
    endtask

    task automatic test_clear();
        logic [apb_data_w-1:0] rd;
        logic                  err;
        test_name = "clear";
        apb_xfer(1'b1, reg_clear, 32'h2, rd, err);
        // clear lands in voice 1's next slot
        idle(8);
        model_acc[1]  = 0;
        model_step[1] = 0;
        send_code(3'd1, 4'h4);
        send_code(3'd0, 4'h3);
        send_code(3'd2, 4'hA);
        wait_drain();
        // 16*9/8 = 18, times 8
        check_pcm(test_name, pcm_t'(144), last_pcm[1]);
    endtask

    task automatic test_disabled_voice();
        logic [apb_data_w-1:0] status;
        int                    i;
        int                    tries;
        test_name = "disabled_voice";
        set_voices(6'b000011);
        for (i = 0; i < 8; i++) begin
            send_code(3'd2, code_t'(rand_bits(4)));
            if (i % 2 == 0) begin
                send_code(3'd0, code_t'(rand_bits(4)));
            end
        end
        tries = 0;
        read_status(status);
        while (status != '0 && tries < 100) begin
            tries++;
            read_status(status);
        end
        check_status(test_name, '0, status);
        wait_drain();
    endtask

    task automatic test_fifo_full();
        logic [apb_data_w-1:0] status;
        logic                  err;
        logic                  done;
        int                    rounds;
        test_name = "fifo_full";
        set_voices(6'b001000);
        send_code(3'd3, code_t'(rand_bits(4)));
        wait_voice_out(3'd3);
        // six clocks per round, two pushes against one pop
        done   = 1'b0;
        rounds = 0;
        while (!done && rounds < 4 * FIFO_DEPTH) begin
            rounds++;
            push_code(3'd3, code_t'(rand_bits(4)), err);
            if (err) begin
                err_count++;
                $display("write refused before the FIFO reported full");
            end
            read_status(status);
            if (status[8]) begin
                check_status(test_name, apb_data_w'(32'h100 | FIFO_DEPTH), status);
                push_code(3'd3, code_t'(rand_bits(4)), err);
                check_count++;
                if (!err) begin
                    err_count++;
                    $display("write to a full FIFO returned no pslverr");
                end
                done = 1'b1;
            end else begin
                push_code(3'd3, code_t'(rand_bits(4)), err);
            end
        end
        if (!done) begin
            err_count++;
            $display("FIFO never reported full");
        end
        wait_drain();
    endtask

    initial begin
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        voice_mask  = '0;
        lfsr_state  = 32'h430eb5d9;
        err_count   = 0;
        check_count = 0;
        test_name   = "reset";
        for (int v = 0; v < num_voices; v++) begin
            model_acc[v]  = 0;
            model_step[v] = 0;
            last_pcm[v]   = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(2);
        test_single_voice();
        test_all_voices();
        test_saturation();
        test_clear();
        test_disabled_voice();
        test_fifo_full();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* adpcm_playback.f */
common/adpcm_pkg.sv
common/nibble_fifo_if.sv
design/adpcm_apb_regs.sv
design/nibble_fifo.sv
adpcm_decoder/adpcm_step_lut.sv
adpcm_decoder/adpcm_decode_pipe.sv
adpcm_decoder/adpcm_slot_sequencer.sv
design/adpcm_playback_top.sv
verif/adpcm_playback_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ADPCM playback testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module adpcm_playback_tb \
    -f adpcm_playback.f -o adpcm_playback_sim \
    && ./obj_dir/adpcm_playback_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "sim passed" sim.log && echo "run_sim: PASS" || { echo "run_sim: FAIL"; exit 1; }
